// File: corr.f
src/corr_pkg.sv
src/line_sampler.sv
src/correlator_bank.sv
src/apb_regs.sv
src/packet_tx.sv
src/correlator_top.sv
sim/tb_correlator.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_correlator
RTL_TOP ?= correlator_top
FILELIST ?= corr.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Test completed successfully
VFLAGS ?= --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_correlator.sv
// testbench for correlator_top; drives APB and the photon lines, checks registers and packets.
`default_nettype none

module tb_correlator
	import corr_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int period = 40;
	localparam int rand_len = 64;
	localparam int long_len = 65535;
	localparam logic [31:0] seed = 32'h6dc4e75b;
	// all windows plus room for APB polling and throttled packets.
	localparam longint budget_cycles = 2 * (2 * rand_len + long_len) + 8000;

	logic intclk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [3:0] line_in;
	logic [7:0] tx_data;
	logic tx_valid;
	logic tx_ready;

	int errors;
	int exp_spec [num_inputs];
	int exp_base [num_baselines];
	int exp_frame;
	logic exp_ovf;
	logic [31:0] line_rng;
	logic [31:0] ready_rng;
	logic [7:0] rx [$];

	correlator_top uut (
		.intclk(intclk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.line_in(line_in), .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
	);

	initial begin
		intclk = 1'b0;
		forever
			#(period / 2) intclk = ~intclk;
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	// one setup and one access phase; results are taken at the closing edge.
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge intclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge intclk);
		penable <= 1'b1;
		@(posedge intclk);
		rdata = prdata;
		err = pslverr;
		check_value("pready", 32'h1, 32'(pready)); // no wait states.
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata, input logic exp_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, wdata, rd, err);
		check_value("pslverr", 32'(exp_err), 32'(err));
	endtask

	task automatic reg_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b0, addr, 32'h0, rd, err);
		check_value("pslverr", 32'h0, 32'(err));
		check_value(name, exp, rd);
	endtask

	task automatic wait_idle();
		logic [31:0] rd;
		logic err;
		do begin
			apb_xfer(1'b0, addr_status, 32'h0, rd, err);
		end while (rd[0]);
	endtask

	// pairs run (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
	task automatic count_edges(input logic [3:0] rise);
		int b;
		b = 0;
		for (int i = 0; i < num_inputs; i++) begin
			if (rise[i]) begin
				if (exp_spec[i] == 65535)
					exp_ovf = 1'b1;
				else
					exp_spec[i]++;
			end
			for (int j = i + 1; j < num_inputs; j++) begin
				if (rise[i] && rise[j]) begin
					if (exp_base[b] == 65535)
						exp_ovf = 1'b1;
					else
						exp_base[b]++;
				end
				b++;
			end
		end
	endtask

	// the burst starts and ends at rest, well inside the window, so the sampler delay
	// never pushes an edge past either end.
	task automatic drive_lines(input int n, input logic toggle, input logic [3:0] mask);
		logic [3:0] prev;
		logic [3:0] cur;
		prev = '0;
		for (int k = 0; k <= n; k++) begin
			if (k == n) begin
				cur = '0;
			end else if (toggle) begin
				cur = {3'b000, ~prev[0]};
			end else begin
				line_rng = lcg(line_rng);
				cur = line_rng[19:16];
			end
			@(posedge intclk);
			line_in <= cur;
			count_edges((cur ^ mask) & ~(prev ^ mask)); // rising edge after the invert.
			prev = cur;
		end
	endtask

	task automatic check_results();
		logic [7:0] want [$];
		for (int i = 0; i < num_inputs; i++)
			reg_check($sformatf("spectra[%0d]", i), addr_spectra + 8'(4 * i), 32'(exp_spec[i]));
		for (int b = 0; b < num_baselines; b++)
			reg_check($sformatf("baselines[%0d]", b), addr_baselines + 8'(4 * b),
				32'(exp_base[b]));
		reg_check("frame", addr_frame, 32'(exp_frame));
		reg_check("status", addr_status, {30'b0, exp_ovf, 1'b0});
		want.push_back(8'ha5);
		want.push_back(8'h43);
		for (int i = 0; i < num_inputs; i++)
			want.push_back(exp_spec[i][15:8]);
		for (int i = 0; i < num_inputs; i++)
			want.insert(2 + 2 * i + 1, exp_spec[i][7:0]);
		for (int b = 0; b < num_baselines; b++) begin
			want.push_back(exp_base[b][15:8]);
			want.push_back(exp_base[b][7:0]);
		end
		want.push_back(exp_frame[15:8]);
		want.push_back(exp_frame[7:0]);
		check_value("packet length", 32'd24, rx.size());
		for (int k = 0; k < want.size() && k < rx.size(); k++)
			check_value($sformatf("tx_data[%0d]", k), 32'(want[k]), 32'(rx[k]));
	endtask

	task automatic run_window(input int len, input logic [3:0] mask, input logic toggle);
		reg_write(addr_ctrl, {24'b0, mask, 4'b0000}, 1'b0); // mask settles before the start.
		reg_write(addr_len, 32'(len), 1'b0);
		for (int i = 0; i < num_inputs; i++)
			exp_spec[i] = 0;
		for (int b = 0; b < num_baselines; b++)
			exp_base[b] = 0;
		exp_ovf = 1'b0;
		rx.delete();
		reg_write(addr_ctrl, {24'b0, mask, 4'b0001}, 1'b0);
		exp_frame++;
		if (len > 8)
			drive_lines(len - 8, toggle, mask);
		wait_idle();
		check_results();
	endtask

	initial begin
		logic [31:0] rd;
		logic err;
		logic held_valid;
		logic [7:0] held_data;
		errors = 0;
		exp_frame = 0;
		line_rng = seed;
		ready_rng = ~seed;
		held_valid = 1'b0;
		held_data = '0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		line_in = '0;
		tx_ready = 1'b0;
		fork
			forever begin
				@(posedge intclk);
				ready_rng = lcg(ready_rng);
				tx_ready <= ready_rng[31] | ready_rng[30]; // ready about 3 cycles in 4.
			end
			forever begin
				@(posedge intclk);
				if (held_valid) begin
					assert (tx_valid && tx_data == held_data) else begin
						$display("%0t: stalled byte was dropped or changed before tx_ready", $time);
						errors++;
					end
				end
				held_valid = tx_valid & ~tx_ready;
				held_data = tx_data;
				if (tx_valid && tx_ready)
					rx.push_back(tx_data);
			end
		join_none
		repeat (3) @(posedge intclk);
		reset <= 1'b0;
		@(posedge intclk);
		check_value("tx_valid", 32'h0, 32'(tx_valid));
		reg_check("status", addr_status, 32'h0);
		reg_check("frame", addr_frame, 32'h0);
		apb_xfer(1'b0, 8'h40, 32'h0, rd, err);
		check_value("pslverr", 32'h1, 32'(err));
		run_window(rand_len, 4'b0000, 1'b0);
		run_window(rand_len, 4'b0101, 1'b0);
		// a line rises at most every other cycle, so even the longest window stays below
		// the counter limit.
		fork
			run_window(long_len, 4'b0000, 1'b1);
			begin
				repeat (200) @(posedge intclk);
				reg_write(addr_ctrl, 32'h1, 1'b1);
				reg_check("frame", addr_frame, 32'(exp_frame - 1));
			end
		join
		run_window(0, 4'b0000, 1'b0);
		$display("checks done with %0d errors", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(budget_cycles * period);
		$display("timeout: the run did not finish within %0d clock cycles", budget_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/correlator_top.sv
// top level of the photon-counting correlator; APB control in, lines in, result packets out.
`default_nettype none

module correlator_top
	import corr_pkg::*;
(
	input wire logic intclk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [apb_addr_width-1:0] paddr,
	input wire logic [apb_data_width-1:0] pwdata,
	output logic [apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire logic [num_inputs-1:0] line_in,
	output logic [7:0] tx_data,
	output logic tx_valid,
	input wire logic tx_ready
);

	corr_ctrl_t ctrl;
	corr_results_t results;
	logic [num_inputs-1:0] pulses;
	logic done;
	logic busy;
	logic tx_busy;

	line_sampler u_sampler (
		.intclk(intclk), .reset(reset), .line_in(line_in),
		.invert(ctrl.invert), .pulses(pulses)
	);

	correlator_bank u_bank (
		.intclk(intclk), .reset(reset), .ctrl(ctrl), .pulses(pulses),
		.tx_busy(tx_busy), .results(results), .done(done), .busy(busy)
	);

	apb_regs u_regs (
		.intclk(intclk), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .results(results),
		.busy(busy), .prdata(prdata), .pready(pready), .pslverr(pslverr), .ctrl(ctrl)
	);

	packet_tx u_tx (
		.intclk(intclk), .reset(reset), .results(results), .done(done),
		.tx_ready(tx_ready), .tx_data(tx_data), .tx_valid(tx_valid), .tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

// File: src/packet_tx.sv
// sends the frozen results as a byte packet over a valid/ready stream after each window.
`default_nettype none

module packet_tx
	import corr_pkg::*;
(
	input wire logic intclk,
	input wire logic reset,
	input wire corr_results_t results,
	input wire logic done,
	input wire logic tx_ready,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic tx_busy
);

	localparam int num_words = num_inputs + num_baselines + 1;
	localparam int idx_width = $clog2(packet_bytes);

	logic sending;
	logic [idx_width-1:0] idx;
	logic [idx_width-1:0] off;
	logic [idx_width-1:0] word_idx;
	logic [num_words*count_width-1:0] words;

	// word 0 is spectrum 0, then baselines, frame last.
	assign words = {results.frame, results.baselines, results.spectra};
	assign off = idx - 2'd2;
	assign word_idx = off >> 1;

	always_comb begin
		if (idx == '0)
			tx_data = sync_byte;
		else if (idx == idx_width'(1))
			tx_data = config_byte;
		else if (!off[0])
			tx_data = words[word_idx*count_width + 8 +: 8]; // msb first.
		else
			tx_data = words[word_idx*count_width +: 8];
	end

	assign tx_valid = sending;
	assign tx_busy = sending;

	always_ff @(posedge intclk) begin
		if (reset) begin
			sending <= 1'b0;
			idx <= '0;
		end else if (done) begin
			sending <= 1'b1;
			idx <= '0;
		end else if (sending && tx_ready) begin
			if (idx == idx_width'(packet_bytes - 1)) begin
				sending <= 1'b0;
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/apb_regs.sv
// APB3 slave holding the window settings and exposing status, frame and the frozen counts.
`default_nettype none

module apb_regs
	import corr_pkg::*;
(
	input wire logic intclk,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [apb_addr_width-1:0] paddr,
	input wire logic [apb_data_width-1:0] pwdata,
	input wire corr_results_t results,
	input wire logic busy,
	output logic [apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output corr_ctrl_t ctrl
);

	logic access;
	logic mapped;
	logic writable;
	logic start_q;
	logic [num_inputs-1:0] invert_q;
	logic [len_width-1:0] len_q;
	logic [apb_addr_width-1:0] spec_off;
	logic [apb_addr_width-1:0] base_off;

	assign access = psel & penable;
	assign pready = 1'b1;
	assign spec_off = (paddr - addr_spectra) >> 2;
	assign base_off = (paddr - addr_baselines) >> 2;

	always_comb begin
		prdata = '0;
		mapped = 1'b0;
		writable = 1'b0;
		if (paddr[1:0] == 2'b00) begin
			if (paddr == addr_ctrl) begin
				mapped = 1'b1;
				writable = 1'b1;
				prdata[4 +: num_inputs] = invert_q; // start always reads 0.
			end else if (paddr == addr_len) begin
				mapped = 1'b1;
				writable = 1'b1;
				prdata[len_width-1:0] = len_q;
			end else if (paddr == addr_status) begin
				mapped = 1'b1;
				prdata[1:0] = {results.overflow, busy};
			end else if (paddr == addr_frame) begin
				mapped = 1'b1;
				prdata[frame_width-1:0] = results.frame;
			end else if (paddr >= addr_spectra && paddr < addr_spectra + 8'(4 * num_inputs)) begin
				mapped = 1'b1;
				prdata[count_width-1:0] = results.spectra[spec_off[$clog2(num_inputs)-1:0]];
			end else if (paddr >= addr_baselines &&
					paddr < addr_baselines + 8'(4 * num_baselines)) begin
				mapped = 1'b1;
				prdata[count_width-1:0] = results.baselines[base_off[$clog2(num_baselines)-1:0]];
			end
		end
	end

	// a start while busy is refused as a whole.
	assign pslverr = access & (~mapped | (pwrite & ~writable) |
		(pwrite & paddr == addr_ctrl & pwdata[0] & busy));

	always_ff @(posedge intclk) begin
		if (reset) begin
			start_q <= 1'b0;
			invert_q <= '0;
			len_q <= '0;
		end else begin
			start_q <= 1'b0;
			if (access && pwrite && !pslverr) begin
				if (paddr == addr_ctrl) begin
					start_q <= pwdata[0];
					invert_q <= pwdata[4 +: num_inputs];
				end else if (paddr == addr_len) begin
					len_q <= pwdata[len_width-1:0];
				end
			end
		end
	end

	assign ctrl = '{start: start_q, invert: invert_q, integ_len: len_q};

endmodule

`default_nettype wire

// File: src/correlator_bank.sv
// integration window, saturating spectrum and baseline counters, and the frozen result snapshot.
`default_nettype none

module correlator_bank
	import corr_pkg::*;
(
	input wire logic intclk,
	input wire logic reset,
	input wire corr_ctrl_t ctrl,
	input wire logic [num_inputs-1:0] pulses,
	input wire logic tx_busy,
	output corr_results_t results,
	output logic done,
	output logic busy
);

	localparam count_t max_count = '1;

	logic active;
	logic [len_width-1:0] remaining;
	count_t [num_inputs-1:0] spec_cnt;
	count_t [num_baselines-1:0] base_cnt;
	logic ovf;
	logic counting;
	logic [num_inputs-1:0] spec_inc;
	logic [num_baselines-1:0] base_inc;
	logic sat_hit;

	assign counting = active && (remaining != '0);
	assign done = active && (remaining == '0); // the cycle after the last counted one.
	assign busy = active | tx_busy;

	always_comb begin
		sat_hit = 1'b0;
		for (int i = 0; i < num_inputs; i++) begin
			spec_inc[i] = counting & pulses[i];
			sat_hit = sat_hit | (spec_inc[i] && spec_cnt[i] == max_count);
		end
		for (int b = 0; b < num_baselines; b++) begin
			base_inc[b] = counting & pulses[pair_a[b]] & pulses[pair_b[b]];
			sat_hit = sat_hit | (base_inc[b] && base_cnt[b] == max_count);
		end
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			active <= 1'b0;
			remaining <= '0;
			spec_cnt <= '0;
			base_cnt <= '0;
			ovf <= 1'b0;
			results <= '0;
		end else if (ctrl.start) begin
			active <= 1'b1;
			remaining <= ctrl.integ_len;
			spec_cnt <= '0;
			base_cnt <= '0;
			ovf <= 1'b0;
		end else if (counting) begin
			remaining <= remaining - 1'b1;
			for (int i = 0; i < num_inputs; i++) begin
				if (spec_inc[i] && spec_cnt[i] != max_count)
					spec_cnt[i] <= spec_cnt[i] + 1'b1;
			end
			for (int b = 0; b < num_baselines; b++) begin
				if (base_inc[b] && base_cnt[b] != max_count)
					base_cnt[b] <= base_cnt[b] + 1'b1;
			end
			ovf <= ovf | sat_hit; // a lost increment marks overflow.
		end else if (done) begin
			// freeze the window.
			active <= 1'b0;
			results.spectra <= spec_cnt;
			results.baselines <= base_cnt;
			results.frame <= results.frame + 1'b1;
			results.overflow <= ovf;
		end
	end

endmodule

`default_nettype wire

// File: src/line_sampler.sv
// brings the asynchronous photon lines into intclk and turns each rising edge into a one-cycle pulse.
`default_nettype none

module line_sampler
	import corr_pkg::*;
(
	input wire logic intclk,
	input wire logic reset,
	input wire logic [num_inputs-1:0] line_in,
	input wire logic [num_inputs-1:0] invert,
	output logic [num_inputs-1:0] pulses
);

	logic [num_inputs-1:0] sync1;
	logic [num_inputs-1:0] sync2;
	logic [num_inputs-1:0] level;
	logic [num_inputs-1:0] prev;

	// inverted lines count their falling edges.
	assign level = sync2 ^ invert;

	always_ff @(posedge intclk) begin
		if (reset) begin
			sync1 <= '0;
			sync2 <= '0;
			prev <= '0;
			pulses <= '0;
		end else begin
			sync1 <= line_in;
			sync2 <= sync1;
			prev <= level;
			pulses <= level & ~prev; // edge register, third stage.
		end
	end

endmodule

`default_nettype wire

// File: src/corr_pkg.sv
// shared sizes, APB register map, packet format and structs of the correlator; import with corr_pkg::*.
`default_nettype none

package corr_pkg;

	localparam int num_inputs = 4;
	localparam int num_baselines = num_inputs * (num_inputs - 1) / 2;
	localparam int count_width = 16;
	localparam int len_width = 16;
	localparam int frame_width = count_width; // frame goes out as one more packet word.

	localparam int apb_addr_width = 8;
	localparam int apb_data_width = 32;

	// packet: sync, config, spectra, baselines, frame.
	localparam logic [7:0] sync_byte = 8'ha5;
	localparam logic [7:0] config_byte = 8'(((count_width / 4) << 4) | (num_inputs - 1));
	localparam int packet_bytes = 2 + 2 * (num_inputs + num_baselines + 1);

	localparam logic [apb_addr_width-1:0] addr_ctrl = 8'h00;
	localparam logic [apb_addr_width-1:0] addr_len = 8'h04;
	localparam logic [apb_addr_width-1:0] addr_status = 8'h08;
	localparam logic [apb_addr_width-1:0] addr_frame = 8'h0c;
	localparam logic [apb_addr_width-1:0] addr_spectra = 8'h10;
	localparam logic [apb_addr_width-1:0] addr_baselines = 8'h20;

	// baseline b correlates line pair_a[b] with line pair_b[b].
	localparam int pair_a [num_baselines] = '{0, 0, 0, 1, 1, 2};
	localparam int pair_b [num_baselines] = '{1, 2, 3, 2, 3, 3};

	typedef logic [count_width-1:0] count_t;

	typedef struct packed {
		logic start; // one cycle pulse.
		logic [num_inputs-1:0] invert;
		logic [len_width-1:0] integ_len;
	} corr_ctrl_t;

	typedef struct packed {
		count_t [num_inputs-1:0] spectra;
		count_t [num_baselines-1:0] baselines;
		logic [frame_width-1:0] frame;
		logic overflow;
	} corr_results_t;

endpackage

`default_nettype wire
